/* bench/legalizer_checker.sv */
/*
 * Legalizer protocol checker
 * concurrent assertions on the top-level handshake, bound into the top
 */
`timescale 1ns/1ps
`default_nettype none

module legalizer_checker (
    input  wire clk_i,
    input  wire reset_i,
    input  wire valid_i,
    input  wire ready_o,
    input  wire flush_i,
    input  wire kill_i,
    input  wire r_valid_o,
    input  wire w_valid_o,
    input  wire w_last_o,
    input  wire r_busy_o,
    input  wire w_busy_o
);

    // flush holds back every burst
    a_no_valid_in_flush: assert property (@(posedge clk_i) disable iff (reset_i)
        flush_i |-> (!r_valid_o && !w_valid_o))
        else $error("burst valid while flush is high");

    // a burst only comes from a side holding a transfer
    a_valid_needs_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        (r_valid_o |-> r_busy_o) and (w_valid_o |-> w_busy_o))
        else $error("burst valid without matching busy");

    // kill empties both sides unless a new request is loaded at once
    a_kill_clears_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        (kill_i && !(valid_i && ready_o)) |=> (!r_busy_o && !w_busy_o))
        else $error("busy still high one cycle after kill");

    // last flag belongs to a write burst
    a_last_with_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        w_last_o |-> w_valid_o)
        else $error("w_last_o without w_valid_o");

endmodule

`default_nettype wire

/* bench/legalizer_patterns.txt */
# src dst length decouple src_red src_llen dst_red dst_llen n_read n_write kill_after stall
# all hex; kill_after is write bursts before a kill (0 none), stall 1 = random readies/flush
# coupled, unaligned, crossing two 1 KiB pages
000012 000311 000834 0 0 0 0 0 5 5 0 0
# decoupled, aligned source, mid-page destination
000000 000200 000800 1 0 0 0 0 2 3 0 0
# decoupled with 64 B and 256 B virtual pages
001000 002020 000200 1 1 4 1 6 8 3 0 0
# coupled with a 32 B destination page
003000 004000 000080 0 0 0 1 3 4 4 0 0
# coupled under random stalls and flush
000005 000402 000c00 0 0 0 0 0 7 7 0 1
# decoupled under random stalls, 128 B destination page
000010 0003fc 000400 1 0 0 1 5 2 9 0 1
# coupled with reduced 512 B source page under stalls
000020 000040 000300 0 1 7 0 0 2 2 0 1
# kill after the first burst pair
000000 000000 001000 0 0 0 0 0 1 1 1 0
# request after the kill
000100 000100 000010 0 0 0 0 0 1 1 0 0
# single byte
000003 000002 000001 0 0 0 0 0 1 1 0 0

/* bench/tb_legalizer.sv */
/*
 * Legalizer testbench
 * replays copy requests from a pattern file and checks every burst
 * against a model of the page cutting rule
 */
`timescale 1ns/1ps
`include "legalizer_defines.svh"
`default_nettype none

module tb_legalizer;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_PATS   = 64;

    logic                        clk_i = 1'b0;
    logic                        reset_i;
    logic [`LEG_ADDR_WIDTH-1:0]  src_addr_i;
    logic [`LEG_ADDR_WIDTH-1:0]  dst_addr_i;
    logic [`LEG_LEN_WIDTH-1:0]   length_i;
    logic                        decouple_rw_i;
    logic                        src_reduce_len_i;
    logic [`LEG_LLEN_WIDTH-1:0]  src_max_llen_i;
    logic                        dst_reduce_len_i;
    logic [`LEG_LLEN_WIDTH-1:0]  dst_max_llen_i;
    logic                        valid_i;
    logic                        ready_o;
    logic [`LEG_ADDR_WIDTH-1:0]  r_addr_o;
    logic [`LEG_MAX_LLEN-1:0]    r_len_o;
    logic                        r_valid_o;
    logic                        r_ready_i;
    logic [`LEG_ADDR_WIDTH-1:0]  w_addr_o;
    logic [`LEG_MAX_LLEN-1:0]    w_len_o;
    logic                        w_last_o;
    logic                        w_valid_o;
    logic                        w_ready_i;
    logic                        flush_i;
    logic                        kill_i;
    logic                        r_busy_o;
    logic                        w_busy_o;

    // pattern table with twelve columns per request
    int pats [MAX_PATS][12];
    int num_pats;

    // expected bursts from the model
    int exp_r_addr[$];
    int exp_r_len[$];
    int exp_w_addr[$];
    int exp_w_len[$];
    bit exp_w_last[$];

    logic [16:0] lfsr_q;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          error_count = 0;

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    legalizer_top DUT (
        .clk_i(clk_i), .reset_i(reset_i),
        .src_addr_i(src_addr_i), .dst_addr_i(dst_addr_i), .length_i(length_i),
        .decouple_rw_i(decouple_rw_i),
        .src_reduce_len_i(src_reduce_len_i), .src_max_llen_i(src_max_llen_i),
        .dst_reduce_len_i(dst_reduce_len_i), .dst_max_llen_i(dst_max_llen_i),
        .valid_i(valid_i), .ready_o(ready_o),
        .r_addr_o(r_addr_o), .r_len_o(r_len_o), .r_valid_o(r_valid_o),
        .r_ready_i(r_ready_i),
        .w_addr_o(w_addr_o), .w_len_o(w_len_o), .w_last_o(w_last_o),
        .w_valid_o(w_valid_o), .w_ready_i(w_ready_i),
        .flush_i(flush_i), .kill_i(kill_i),
        .r_busy_o(r_busy_o), .w_busy_o(w_busy_o)
    );

    bind legalizer_top legalizer_checker u_checker (
        .clk_i(clk_i), .reset_i(reset_i), .valid_i(valid_i), .ready_o(ready_o),
        .flush_i(flush_i), .kill_i(kill_i), .r_valid_o(r_valid_o),
        .w_valid_o(w_valid_o), .w_last_o(w_last_o),
        .r_busy_o(r_busy_o), .w_busy_o(w_busy_o)
    );

    // run limit counted on every rising edge
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: transfers did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic report_error(input string msg);
        error_count++;
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "check failed");
    endtask

    // fibonacci LFSR x^17 + x^14 + 1 stepped once per bit
    function automatic bit next_random_bit();
        bit fb;
        fb     = lfsr_q[16] ^ lfsr_q[13];
        lfsr_q = {lfsr_q[15:0], fb};
        return fb;
    endfunction

    // bytes left to the (virtual) page boundary
    function automatic int page_bytes(input int addr, input int red, input int llen);
        int pw;
        int size;
        pw = `LEG_OFFSET_WIDTH + (red != 0 ? llen : `LEG_MAX_LLEN);
        if (pw > `LEG_PAGE_ADDR_WIDTH) begin
            pw = `LEG_PAGE_ADDR_WIDTH;
        end
        size = 1 << pw;
        return size - (addr & (size - 1));
    endfunction

    task automatic push_burst(input bit wside, input int a, input int b, input bit last);
        int beats_m1;
        beats_m1 = (b + (a % `LEG_STRB_WIDTH) - 1) / `LEG_STRB_WIDTH;
        if (wside) begin
            exp_w_addr.push_back(a & ~(`LEG_STRB_WIDTH - 1));
            exp_w_len.push_back(beats_m1);
            exp_w_last.push_back(last);
        end else begin
            exp_r_addr.push_back(a & ~(`LEG_STRB_WIDTH - 1));
            exp_r_len.push_back(beats_m1);
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model of the cutting rule
    // ------------------------------------------------------------------------
    task automatic build_expected(input int p);
        int ra;
        int wa;
        int rrem;
        int wrem;
        int bp;
        int b;
        ra   = pats[p][0];
        wa   = pats[p][1];
        rrem = pats[p][2];
        wrem = pats[p][2];
        while (rrem > 0 || wrem > 0) begin
            if (pats[p][3] != 0) begin
                // decoupled sides cut at their own boundary
                if (rrem > 0) begin
                    bp = page_bytes(ra, pats[p][4], pats[p][5]);
                    b  = (rrem < bp) ? rrem : bp;
                    push_burst(1'b0, ra, b, rrem <= bp);
                    ra   += b;
                    rrem -= b;
                end
                if (wrem > 0) begin
                    bp = page_bytes(wa, pats[p][6], pats[p][7]);
                    b  = (wrem < bp) ? wrem : bp;
                    push_burst(1'b1, wa, b, wrem <= bp);
                    wa   += b;
                    wrem -= b;
                end
            end else begin
                // coupled sides cut at the closer boundary
                bp = page_bytes(ra, pats[p][4], pats[p][5]);
                if (page_bytes(wa, pats[p][6], pats[p][7]) < bp) begin
                    bp = page_bytes(wa, pats[p][6], pats[p][7]);
                end
                b = (rrem < bp) ? rrem : bp;
                push_burst(1'b0, ra, b, rrem <= bp);
                push_burst(1'b1, wa, b, rrem <= bp);
                ra += b;
                wa += b;
                rrem -= b;
                wrem -= b;
            end
        end
    endtask

    task automatic check_read_burst();
        int ea;
        int el;
        assert (exp_r_addr.size() > 0) else report_error("read burst with none expected");
        ea = exp_r_addr.pop_front();
        el = exp_r_len.pop_front();
        assert (int'(r_addr_o) == ea && int'(r_len_o) == el)
            else report_error($sformatf("read burst got %h/%0d expected %h/%0d",
                                        r_addr_o, r_len_o, ea, el));
    endtask

    task automatic check_write_burst();
        int ea;
        int el;
        bit elast;
        assert (exp_w_addr.size() > 0) else report_error("write burst with none expected");
        ea    = exp_w_addr.pop_front();
        el    = exp_w_len.pop_front();
        elast = exp_w_last.pop_front();
        assert (int'(w_addr_o) == ea && int'(w_len_o) == el && w_last_o == elast)
            else report_error($sformatf("write burst got %h/%0d/%b expected %h/%0d/%b",
                                        w_addr_o, w_len_o, w_last_o, ea, el, elast));
    endtask

    // ------------------------------------------------------------------------
    // one request from issue to its last burst or its kill
    // ------------------------------------------------------------------------
    task automatic run_pattern(input int p);
        int r_seen;
        int w_seen;
        bit accepted;
        bit finished;
        bit b0;
        bit b1;
        bit b2;
        build_expected(p);
        // model and file agree on full transfers
        if (pats[p][10] == 0) begin
            assert (exp_r_addr.size() == pats[p][8] && exp_w_addr.size() == pats[p][9])
                else report_error($sformatf("model gives %0d/%0d bursts, file %0d/%0d",
                    exp_r_addr.size(), exp_w_addr.size(), pats[p][8], pats[p][9]));
        end
        r_seen   = 0;
        w_seen   = 0;
        accepted = 1'b0;
        finished = 1'b0;
        while (!finished) begin
            @(posedge clk_i);
            #1;
            src_addr_i       = pats[p][0][`LEG_ADDR_WIDTH-1:0];
            dst_addr_i       = pats[p][1][`LEG_ADDR_WIDTH-1:0];
            length_i         = pats[p][2][`LEG_LEN_WIDTH-1:0];
            decouple_rw_i    = pats[p][3] != 0;
            src_reduce_len_i = pats[p][4] != 0;
            src_max_llen_i   = pats[p][5][`LEG_LLEN_WIDTH-1:0];
            dst_reduce_len_i = pats[p][6] != 0;
            dst_max_llen_i   = pats[p][7][`LEG_LLEN_WIDTH-1:0];
            valid_i          = !accepted;
            kill_i           = 1'b0;
            if (pats[p][10] != 0 && w_seen >= pats[p][10]) begin
                // kill with both readies low so no burst slips out
                kill_i    = 1'b1;
                r_ready_i = 1'b0;
                w_ready_i = 1'b0;
                flush_i   = 1'b0;
            end else if (pats[p][11] != 0) begin
                b0 = next_random_bit();
                b1 = next_random_bit();
                r_ready_i = b0 | b1;
                b0 = next_random_bit();
                b1 = next_random_bit();
                w_ready_i = b0 | b1;
                b0 = next_random_bit();
                b1 = next_random_bit();
                b2 = next_random_bit();
                flush_i = b0 & b1 & b2;
            end else begin
                r_ready_i = 1'b1;
                w_ready_i = 1'b1;
                flush_i   = 1'b0;
            end
            #(CLK_PERIOD/2 - 1);
            if (kill_i) begin
                @(posedge clk_i);
                #1;
                kill_i    = 1'b0;
                r_ready_i = 1'b1;
                w_ready_i = 1'b1;
                #(CLK_PERIOD/2 - 1);
                assert (!r_busy_o && !w_busy_o) else report_error("busy still high after kill");
                finished = 1'b1;
            end else begin
                if (valid_i && ready_o) begin
                    accepted = 1'b1;
                end
                if (flush_i) begin
                    assert (!r_valid_o && !w_valid_o) else report_error("burst during flush");
                end
                if (r_valid_o) begin
                    check_read_burst();
                    r_seen++;
                end
                if (w_valid_o) begin
                    check_write_burst();
                    w_seen++;
                end
                if (accepted && pats[p][10] == 0 && exp_r_addr.size() == 0
                    && exp_w_addr.size() == 0) begin
                    finished = 1'b1;
                end
            end
        end
        valid_i = 1'b0;
        assert (r_seen == pats[p][8] && w_seen == pats[p][9])
            else report_error($sformatf("pattern %0d took %0d/%0d bursts, expected %0d/%0d",
                                        p, r_seen, w_seen, pats[p][8], pats[p][9]));
        exp_r_addr.delete();
        exp_r_len.delete();
        exp_w_addr.delete();
        exp_w_len.delete();
        exp_w_last.delete();
    endtask

    task automatic read_patterns();
        int    fd;
        int    n;
        int    f [12];
        string line;
        fd = $fopen("bench/legalizer_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            $display("Errors found");
            $fatal(1, "missing stimulus");
        end
        num_pats = 0;
        while (!$feof(fd) && num_pats < MAX_PATS) begin
            line = "";
            n    = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5],
                            f[6], f[7], f[8], f[9], f[10], f[11]);
                if (n == 12) begin
                    for (int i = 0; i < 12; i++) begin
                        pats[num_pats][i] = f[i];
                    end
                    num_pats++;
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        lfsr_q           = 17'd78503;
        reset_i          = 1'b1;
        src_addr_i       = '0;
        dst_addr_i       = '0;
        length_i         = '0;
        decouple_rw_i    = 1'b0;
        src_reduce_len_i = 1'b0;
        src_max_llen_i   = '0;
        dst_reduce_len_i = 1'b0;
        dst_max_llen_i   = '0;
        valid_i          = 1'b0;
        r_ready_i        = 1'b1;
        w_ready_i        = 1'b1;
        flush_i          = 1'b0;
        kill_i           = 1'b0;
        read_patterns();
        cycle_limit = 200 * num_pats + 100;
        repeat (4) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        // idle state after reset
        #(CLK_PERIOD/2 - 1);
        assert (!r_valid_o && !w_valid_o && !r_busy_o && !w_busy_o && ready_o)
            else report_error("outputs not idle after reset");
        for (int p = 0; p < num_pats; p++) begin
            run_pattern(p);
        end
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/legalizer_defines.svh */
/*
 * AXI4 burst legalizer constants
 * widths, burst beat limit and page address limit for a 32-bit data path
 */
`ifndef LEGALIZER_DEFINES_SVH
`define LEGALIZER_DEFINES_SVH

`default_nettype none

// byte address and transfer length widths
`define LEG_ADDR_WIDTH 24
`define LEG_LEN_WIDTH 24

// 32-bit data bus, four byte lanes
`define LEG_STRB_WIDTH 4
`define LEG_OFFSET_WIDTH 2

// 256 beats per burst at most
`define LEG_MAX_LLEN 8
// 1 KiB page from 256 beats of 4 bytes, well under the 4 KiB rule
`define LEG_PAGE_ADDR_WIDTH 10
`define LEG_LLEN_WIDTH 3

`default_nettype wire

`endif

/* common/legalizer_pkg.sv */
/*
 * Legalizer types
 * address, length and burst length types plus the per-side state
 */
`include "legalizer_defines.svh"

`default_nettype none

package legalizer_pkg;

    // byte address of a source or destination
    typedef logic [`LEG_ADDR_WIDTH-1:0] addr_t;

    // remaining transfer length in bytes
    typedef logic [`LEG_LEN_WIDTH-1:0] len_t;

    // one extra bit so a full page still fits
    typedef logic [`LEG_PAGE_ADDR_WIDTH:0] page_len_t;

    // log2 of the reduced burst length in beats
    typedef logic [`LEG_LLEN_WIDTH-1:0] llen_t;

    // AXI beats minus one
    typedef logic [`LEG_MAX_LLEN-1:0] axi_len_t;

    // each side is either cutting a transfer or waiting for one
    typedef enum logic {
        SIDE_IDLE   = 1'b0,
        SIDE_ACTIVE = 1'b1
    } side_state_e;

endpackage

`default_nettype wire

/* hw/legalizer/burst_splitter.sv */
/*
 * Burst splitter
 * holds one side's address and remaining length and cuts off one burst
 * per step, giving the aligned burst address and the AXI length
 */
`timescale 1ns/1ps
`include "legalizer_defines.svh"
`default_nettype none

module burst_splitter (
    input  wire                        clk_i,
    input  wire                        reset_i,
    input  wire                        load_i,
    input  wire legalizer_pkg::addr_t  load_addr_i,
    input  wire legalizer_pkg::len_t   load_len_i,
    input  wire                        step_i,
    input  wire                        kill_i,
    input  wire                        reduce_len_i,
    input  wire legalizer_pkg::llen_t  max_llen_i,
    input  wire legalizer_pkg::page_len_t bytes_possible_i,
    output legalizer_pkg::page_len_t   bytes_to_pb_o,
    output logic                       done_o,
    output logic                       active_o,
    output legalizer_pkg::addr_t       addr_o,
    output legalizer_pkg::axi_len_t    len_o
);
    import legalizer_pkg::*;

    side_state_e state_q;
    addr_t       addr_q;
    len_t        len_q;

    page_len_t   burst_bytes;
    page_len_t   beat_span;
    logic        last_burst;

    // distance of the current address to its page boundary
    page_boundary_calc u_pb (
        .addr_i        (addr_q),
        .reduce_len_i  (reduce_len_i),
        .max_llen_i    (max_llen_i),
        .bytes_to_pb_o (bytes_to_pb_o)
    );

    // -------------------------------------------------------------------------
    // burst size
    // -------------------------------------------------------------------------
    always_comb begin
        if (len_q > len_t'(bytes_possible_i)) begin
            // more left than fits, cut at the boundary
            burst_bytes = bytes_possible_i;
            last_burst  = 1'b0;
        end else begin
            // the rest fits in this burst
            burst_bytes = len_q[`LEG_PAGE_ADDR_WIDTH:0];
            last_burst  = 1'b1;
        end
    end

    // bytes covered from the aligned start, minus one
    assign beat_span = burst_bytes + page_len_t'(addr_q[`LEG_OFFSET_WIDTH-1:0])
                     - page_len_t'(1);

    assign len_o    = axi_len_t'(beat_span / `LEG_STRB_WIDTH);
    assign addr_o   = {addr_q[`LEG_ADDR_WIDTH-1:`LEG_OFFSET_WIDTH], {`LEG_OFFSET_WIDTH{1'b0}}};
    assign active_o = (state_q == SIDE_ACTIVE);
    // a kill ends the transfer as well
    assign done_o   = last_burst | kill_i;

    // -------------------------------------------------------------------------
    // transfer state
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= SIDE_IDLE;
            addr_q  <= '0;
            len_q   <= '0;
        end else if (load_i) begin
            // new request wins over kill
            state_q <= SIDE_ACTIVE;
            addr_q  <= load_addr_i;
            len_q   <= load_len_i;
        end else if (kill_i) begin
            state_q <= SIDE_IDLE;
            addr_q  <= '0;
            len_q   <= '0;
        end else if (step_i && state_q == SIDE_ACTIVE) begin
            if (last_burst) begin
                state_q <= SIDE_IDLE;
            end else begin
                len_q  <= len_q - len_t'(burst_bytes);
                addr_q <= addr_q + addr_t'(burst_bytes);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/legalizer/legalizer_flow_ctrl.sv */
/*
 * Legalizer flow control
 * couples the sides, gates steps and valids, and forms request ready
 */
`timescale 1ns/1ps
`default_nettype none

module legalizer_flow_ctrl (
    input  wire                           decouple_rw_i,
    input  wire legalizer_pkg::page_len_t r_bytes_to_pb_i,
    input  wire legalizer_pkg::page_len_t w_bytes_to_pb_i,
    input  wire                           r_active_i,
    input  wire                           w_active_i,
    input  wire                           r_done_i,
    input  wire                           w_done_i,
    input  wire                           r_ready_i,
    input  wire                           w_ready_i,
    input  wire                           flush_i,
    input  wire                           valid_i,
    output legalizer_pkg::page_len_t      r_bytes_possible_o,
    output legalizer_pkg::page_len_t      w_bytes_possible_o,
    output logic                          r_step_o,
    output logic                          w_step_o,
    output logic                          r_valid_o,
    output logic                          w_valid_o,
    output logic                          ready_o,
    output logic                          accept_o
);
    import legalizer_pkg::*;

    page_len_t c_bytes_to_pb;
    logic      r_go;
    logic      w_go;

    // coupled sides cut at whichever boundary comes first
    assign c_bytes_to_pb = (r_bytes_to_pb_i > w_bytes_to_pb_i) ? w_bytes_to_pb_i
                                                               : r_bytes_to_pb_i;

    assign r_bytes_possible_o = decouple_rw_i ? r_bytes_to_pb_i : c_bytes_to_pb;
    assign w_bytes_possible_o = decouple_rw_i ? w_bytes_to_pb_i : c_bytes_to_pb;

    // -------------------------------------------------------------------------
    // step enables
    // -------------------------------------------------------------------------
    // coupled mode needs both readies, flush freezes everything
    assign r_go = r_ready_i & (decouple_rw_i | w_ready_i) & ~flush_i;
    assign w_go = w_ready_i & (decouple_rw_i | r_ready_i) & ~flush_i;

    assign r_step_o  = r_go;
    assign w_step_o  = w_go;
    assign r_valid_o = r_active_i & r_go;
    assign w_valid_o = w_active_i & w_go;

    // take a new request once both sides finish or sit idle
    assign ready_o  = (r_done_i | ~r_active_i) & (w_done_i | ~w_active_i)
                    & r_ready_i & w_ready_i & ~flush_i;
    assign accept_o = ready_o & valid_i;

endmodule

`default_nettype wire

/* hw/legalizer/legalizer_top.sv */
/*
 * AXI4 burst legalizer
 * cuts a 1D copy request into read and write bursts that stay inside
 * a (virtual) page and never exceed 256 beats
 */
`timescale 1ns/1ps
`default_nettype none

module legalizer_top (
    input  wire                     clk_i,
    input  wire                     reset_i,

    // copy request
    input  wire legalizer_pkg::addr_t src_addr_i,
    input  wire legalizer_pkg::addr_t dst_addr_i,
    input  wire legalizer_pkg::len_t  length_i,
    input  wire                     decouple_rw_i,
    input  wire                     src_reduce_len_i,
    input  wire legalizer_pkg::llen_t src_max_llen_i,
    input  wire                     dst_reduce_len_i,
    input  wire legalizer_pkg::llen_t dst_max_llen_i,
    input  wire                     valid_i,
    output logic                    ready_o,

    // read bursts
    output legalizer_pkg::addr_t    r_addr_o,
    output legalizer_pkg::axi_len_t r_len_o,
    output logic                    r_valid_o,
    input  wire                     r_ready_i,

    // write bursts
    output legalizer_pkg::addr_t    w_addr_o,
    output legalizer_pkg::axi_len_t w_len_o,
    output logic                    w_last_o,
    output logic                    w_valid_o,
    input  wire                     w_ready_i,

    input  wire                     flush_i,
    input  wire                     kill_i,
    output logic                    r_busy_o,
    output logic                    w_busy_o
);
    import legalizer_pkg::*;

    // options of the transfer in flight
    logic      decouple_rw;
    logic      src_reduce_len;
    llen_t     src_max_llen;
    logic      dst_reduce_len;
    llen_t     dst_max_llen;

    // splitter status back to flow control
    page_len_t r_bytes_to_pb;
    page_len_t w_bytes_to_pb;
    page_len_t r_bytes_possible;
    page_len_t w_bytes_possible;
    logic      r_active;
    logic      w_active;
    logic      r_done;
    logic      w_done;

    // step and load strobes
    logic      r_step;
    logic      w_step;
    logic      accept;

    transfer_opts_reg u_opts (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .accept_i         (accept),
        .decouple_rw_i    (decouple_rw_i),
        .src_reduce_len_i (src_reduce_len_i),
        .src_max_llen_i   (src_max_llen_i),
        .dst_reduce_len_i (dst_reduce_len_i),
        .dst_max_llen_i   (dst_max_llen_i),
        .decouple_rw_o    (decouple_rw),
        .src_reduce_len_o (src_reduce_len),
        .src_max_llen_o   (src_max_llen),
        .dst_reduce_len_o (dst_reduce_len),
        .dst_max_llen_o   (dst_max_llen)
    );

    legalizer_flow_ctrl u_flow (
        .decouple_rw_i      (decouple_rw),
        .r_bytes_to_pb_i    (r_bytes_to_pb),
        .w_bytes_to_pb_i    (w_bytes_to_pb),
        .r_active_i         (r_active),
        .w_active_i         (w_active),
        .r_done_i           (r_done),
        .w_done_i           (w_done),
        .r_ready_i          (r_ready_i),
        .w_ready_i          (w_ready_i),
        .flush_i            (flush_i),
        .valid_i            (valid_i),
        .r_bytes_possible_o (r_bytes_possible),
        .w_bytes_possible_o (w_bytes_possible),
        .r_step_o           (r_step),
        .w_step_o           (w_step),
        .r_valid_o          (r_valid_o),
        .w_valid_o          (w_valid_o),
        .ready_o            (ready_o),
        .accept_o           (accept)
    );

    // source side
    burst_splitter u_read (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .load_i           (accept),
        .load_addr_i      (src_addr_i),
        .load_len_i       (length_i),
        .step_i           (r_step),
        .kill_i           (kill_i),
        .reduce_len_i     (src_reduce_len),
        .max_llen_i       (src_max_llen),
        .bytes_possible_i (r_bytes_possible),
        .bytes_to_pb_o    (r_bytes_to_pb),
        .done_o           (r_done),
        .active_o         (r_active),
        .addr_o           (r_addr_o),
        .len_o            (r_len_o)
    );

    // destination side
    burst_splitter u_write (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .load_i           (accept),
        .load_addr_i      (dst_addr_i),
        .load_len_i       (length_i),
        .step_i           (w_step),
        .kill_i           (kill_i),
        .reduce_len_i     (dst_reduce_len),
        .max_llen_i       (dst_max_llen),
        .bytes_possible_i (w_bytes_possible),
        .bytes_to_pb_o    (w_bytes_to_pb),
        .done_o           (w_done),
        .active_o         (w_active),
        .addr_o           (w_addr_o),
        .len_o            (w_len_o)
    );

    // busy while a side still holds a transfer
    assign r_busy_o = r_active;
    assign w_busy_o = w_active;

    // final write burst of the 1D transfer
    assign w_last_o = w_done & w_valid_o;

endmodule

`default_nettype wire

/* hw/legalizer/page_boundary_calc.sv */
/*
 * Page boundary distance
 * bytes left until the next virtual page boundary of one address
 */
`timescale 1ns/1ps
`include "legalizer_defines.svh"
`default_nettype none

module page_boundary_calc (
    input  wire legalizer_pkg::addr_t  addr_i,
    input  wire                        reduce_len_i,
    input  wire legalizer_pkg::llen_t  max_llen_i,
    output legalizer_pkg::page_len_t   bytes_to_pb_o
);
    import legalizer_pkg::*;

    logic [3:0] page_addr_width;
    page_len_t  page_size;
    page_len_t  page_offset;

    // -------------------------------------------------------------------------
    // page width in address bits
    // -------------------------------------------------------------------------
    always_comb begin
        // a reduced length shrinks the page to 2**max_llen beats
        if (reduce_len_i) begin
            page_addr_width = 4'(`LEG_OFFSET_WIDTH) + 4'(max_llen_i);
        end else begin
            page_addr_width = 4'(`LEG_OFFSET_WIDTH) + 4'(`LEG_MAX_LLEN);
        end
        // never larger than a full 256-beat page
        if (page_addr_width > 4'(`LEG_PAGE_ADDR_WIDTH)) begin
            page_addr_width = 4'(`LEG_PAGE_ADDR_WIDTH);
        end
    end

    assign page_size = page_len_t'(1) << page_addr_width;

    // low address bits inside the page, masked with size minus one
    assign page_offset = page_len_t'(addr_i[`LEG_PAGE_ADDR_WIDTH-1:0])
                       & (page_size - page_len_t'(1));

    // distance to the boundary, a full page when aligned
    assign bytes_to_pb_o = page_size - page_offset;

endmodule

`default_nettype wire

/* hw/legalizer/transfer_opts_reg.sv */
/*
 * Transfer options register
 * captures coupling and reduced-length options when a request is taken
 */
`timescale 1ns/1ps
`default_nettype none

module transfer_opts_reg (
    input  wire                        clk_i,
    input  wire                        reset_i,
    input  wire                        accept_i,
    input  wire                        decouple_rw_i,
    input  wire                        src_reduce_len_i,
    input  wire legalizer_pkg::llen_t  src_max_llen_i,
    input  wire                        dst_reduce_len_i,
    input  wire legalizer_pkg::llen_t  dst_max_llen_i,
    output logic                       decouple_rw_o,
    output logic                       src_reduce_len_o,
    output legalizer_pkg::llen_t       src_max_llen_o,
    output logic                       dst_reduce_len_o,
    output legalizer_pkg::llen_t       dst_max_llen_o
);
    import legalizer_pkg::*;

    // registered copies, steering the splitters for the whole transfer
    logic  decouple_rw_q;
    logic  src_reduce_len_q;
    llen_t src_max_llen_q;
    logic  dst_reduce_len_q;
    llen_t dst_max_llen_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            decouple_rw_q    <= 1'b0;
            src_reduce_len_q <= 1'b0;
            src_max_llen_q   <= '0;
            dst_reduce_len_q <= 1'b0;
            dst_max_llen_q   <= '0;
        end else if (accept_i) begin
            decouple_rw_q    <= decouple_rw_i;
            src_reduce_len_q <= src_reduce_len_i;
            src_max_llen_q   <= src_max_llen_i;
            dst_reduce_len_q <= dst_reduce_len_i;
            dst_max_llen_q   <= dst_max_llen_i;
        end
    end

    assign decouple_rw_o    = decouple_rw_q;
    assign src_reduce_len_o = src_reduce_len_q;
    assign src_max_llen_o   = src_max_llen_q;
    assign dst_reduce_len_o = dst_reduce_len_q;
    assign dst_max_llen_o   = dst_max_llen_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the legalizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_legalizer -f vlog.f -o sim_legalizer

# the simulation exits non-zero on failure, the log decides
./obj_dir/sim_legalizer > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

/* vlog.f */
+incdir+common
common/legalizer_pkg.sv
hw/legalizer/page_boundary_calc.sv
hw/legalizer/burst_splitter.sv
hw/legalizer/transfer_opts_reg.sv
hw/legalizer/legalizer_flow_ctrl.sv
hw/legalizer/legalizer_top.sv
bench/legalizer_checker.sv
bench/tb_legalizer.sv
